//--- Makefile
# Verilator build, run and lint for the execute core

VERILATOR ?= verilator
TOP       ?= execCore_tb
LINT_TOP  ?= execCore
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- execCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three-lane execute core top level
// Register read, EX1 ALU stage, EX2 writeback stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "execCore_params.svh"

module execCore (
	input  logic                      clock,
	input  logic                      rstN,
	input  logic                      hold,
	input  laneOps_pkg::issueBundle_t issue,
	input  regDefs_pkg::ctrlRegs_t    ctrlRegs,
	input  regDefs_pkg::sprVals_t     sprIn,
	output regDefs_pkg::wbBundle_t    wbLanes,
	output regDefs_pkg::sprVals_t     sprOut
);

	// Idle lanes target ZZR so nothing is written out of reset
	localparam laneOps_pkg::laneOperands_t idleOperands =
		'{op: laneOps_pkg::ALU_MOV, aVal: '0, bVal: '0, rn: `GR_ZZR};
	localparam laneOps_pkg::ex1Bundle_t ex1Reset =
		'{a: idleOperands, b: idleOperands, c: idleOperands};
	localparam regDefs_pkg::writePort_t idleWrite = '{id: `GR_ZZR, value: '0};
	localparam regDefs_pkg::wbBundle_t ex2Reset = '{a: idleWrite, b: idleWrite, c: idleWrite};

	laneOps_pkg::ex1Bundle_t operandsRead;	// Combinational read result
	laneOps_pkg::ex1Bundle_t operandsEx1;
	regDefs_pkg::wbBundle_t resultsEx1;

	gprFile regFile (
		.clock(clock), .rstN(rstN), .hold(hold),
		.issue(issue), .ctrlRegs(ctrlRegs), .sprIn(sprIn),
		.fwdEx1(resultsEx1), .wbEx2(wbLanes),
		.operands(operandsRead), .sprOut(sprOut)
	);

	pipeStage #(.payload_t(laneOps_pkg::ex1Bundle_t), .resetValue(ex1Reset)) ex1Stage (
		.clock(clock), .rstN(rstN), .hold(hold),
		.d(operandsRead), .q(operandsEx1)
	);

	laneAlu alu (
		.operands(operandsEx1),
		.results(resultsEx1)
	);

	// EX2 output feeds both the write ports and the core outputs
	pipeStage #(.payload_t(regDefs_pkg::wbBundle_t), .resetValue(ex2Reset)) ex2Stage (
		.clock(clock), .rstN(rstN), .hold(hold),
		.d(resultsEx1), .q(wbLanes)
	);

endmodule

//--- execCore_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute core widths
// Register id encodings for GPRs, specials, control values and pseudo ids
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef EXECCORE_PARAMS_SVH
`define EXECCORE_PARAMS_SVH

`define XLEN		64	// Register value width
`define REG_ID_W	6
`define IMM_W		33	// Top bit is the sign
`define CTRL_W		32

// Ids with the top bit clear name general registers
`define GR_DLR	6'd32
`define GR_DHR	6'd33
`define GR_PC	6'd34
`define GR_GBR	6'd35
`define GR_LR	6'd36
`define GR_SP	6'd47
`define GR_IMM	6'd62	// Lane immediate, sign extended
`define GR_ZZR	6'd63	// Reads zero, writes dropped

`endif

//--- execCore_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute core testbench
// Reference register and pipeline model
// Directed tests and closing report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "execCore_params.svh"

module execCore_tb;

	logic clock;
	logic rstN;
	logic hold;
	laneOps_pkg::issueBundle_t issue;
	regDefs_pkg::ctrlRegs_t ctrlRegs;
	regDefs_pkg::sprVals_t sprIn;
	regDefs_pkg::wbBundle_t wbLanes;
	regDefs_pkg::sprVals_t sprOut;

	regDefs_pkg::regVal_t modelRegs [32];
	regDefs_pkg::sprVals_t sprModel;
	regDefs_pkg::wbBundle_t readExp;	// Issue being read this cycle
	regDefs_pkg::wbBundle_t ex1Exp;
	regDefs_pkg::wbBundle_t ex2Exp;	// Should match wbLanes
	regDefs_pkg::sprVals_t sideNext;
	logic holdNext;
	int errorCount;
	int checkCount;
	int timeoutCount;

	localparam regDefs_pkg::writePort_t idleWrite = '{id: `GR_ZZR, value: '0};

	execCore DUT (
		.clock(clock), .rstN(rstN), .hold(hold), .issue(issue),
		.ctrlRegs(ctrlRegs), .sprIn(sprIn), .wbLanes(wbLanes), .sprOut(sprOut)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic regDefs_pkg::regVal_t signExt(input regDefs_pkg::imm_t imm);
		return 64'($signed(imm));
	endfunction

	function automatic regDefs_pkg::imm_t randImm();
		logic [63:0] r;
		r = {$urandom, $urandom};
		return r[`IMM_W-1:0];
	endfunction

	function automatic laneOps_pkg::laneIssue_t aluLane(input laneOps_pkg::aluOp_t op,
			input regDefs_pkg::regId_t rs, input regDefs_pkg::regId_t rt,
			input regDefs_pkg::regId_t rn);
		return '{op: op, rs: rs, rt: rt, rn: rn, imm: '0};
	endfunction

	function automatic laneOps_pkg::laneIssue_t movImm(input regDefs_pkg::regId_t rn,
			input regDefs_pkg::imm_t imm);
		return '{op: laneOps_pkg::ALU_MOV, rs: `GR_IMM, rt: `GR_ZZR, rn: rn, imm: imm};
	endfunction

	function automatic laneOps_pkg::laneIssue_t nopLane();
		return aluLane(laneOps_pkg::ALU_MOV, `GR_ZZR, `GR_ZZR, `GR_ZZR);
	endfunction

	function automatic laneOps_pkg::issueBundle_t idleOps();
		return '{a: nopLane(), b: nopLane(), c: nopLane()};
	endfunction

	function automatic regDefs_pkg::regVal_t storedValue(input regDefs_pkg::regId_t id);
		if (!id[`REG_ID_W-1])
			return modelRegs[id[`REG_ID_W-2:0]];
		case (id)
			`GR_DLR: return sprModel.dlr;
			`GR_DHR: return sprModel.dhr;
			`GR_SP:  return sprModel.sp;
			`GR_PC:  return 64'(ctrlRegs.pc);	// Zero extended
			`GR_GBR: return 64'(ctrlRegs.gbr);
			`GR_LR:  return 64'(ctrlRegs.lr);
			default: return '0;
		endcase
	endfunction

	// EX1 before EX2, lane A before B before C
	function automatic regDefs_pkg::regVal_t modelRead(input regDefs_pkg::regId_t id,
			input regDefs_pkg::imm_t imm);
		regDefs_pkg::writePort_t fwd [6];
		regDefs_pkg::regVal_t val;
		logic hit;
		fwd = '{ex1Exp.a, ex1Exp.b, ex1Exp.c, ex2Exp.a, ex2Exp.b, ex2Exp.c};
		hit = 1'b0;
		val = '0;
		if (id == `GR_IMM)
			val = signExt(imm);
		else if (id != `GR_ZZR) begin
			for (int i = 0; i < 6; i++) begin
				if (!hit && fwd[i].id == id) begin
					val = fwd[i].value;
					hit = 1'b1;
				end
			end
			if (!hit)
				val = storedValue(id);
		end
		return val;
	endfunction

	function automatic regDefs_pkg::regVal_t aluModel(input laneOps_pkg::aluOp_t op,
			input regDefs_pkg::regVal_t a, input regDefs_pkg::regVal_t b);
		case (op)
			laneOps_pkg::ALU_ADD: return a + b;
			laneOps_pkg::ALU_SUB: return a - b;
			laneOps_pkg::ALU_AND: return a & b;
			laneOps_pkg::ALU_OR:  return a | b;
			laneOps_pkg::ALU_XOR: return a ^ b;
			laneOps_pkg::ALU_SHL: return a << b[5:0];
			default:              return a;
		endcase
	endfunction

	function automatic regDefs_pkg::writePort_t predictLane(input laneOps_pkg::laneIssue_t op);
		return '{id: op.rn,
			value: aluModel(op.op, modelRead(op.rs, op.imm), modelRead(op.rt, op.imm))};
	endfunction

	// Apply one EX2 bundle to the stored model
	task automatic retire(input regDefs_pkg::wbBundle_t wb, input regDefs_pkg::sprVals_t side);
		regDefs_pkg::writePort_t ports [3];
		ports = '{wb.a, wb.b, wb.c};
		for (int l = 0; l < 3; l++) begin
			if (!ports[l].id[`REG_ID_W-1])
				modelRegs[ports[l].id[`REG_ID_W-2:0]] = ports[l].value;	// C lands last
		end
		sprModel = side;
		for (int l = 2; l >= 0; l--) begin	// A lands last for specials
			if (ports[l].id == `GR_DLR) sprModel.dlr = ports[l].value;
			if (ports[l].id == `GR_DHR) sprModel.dhr = ports[l].value;
			if (ports[l].id == `GR_SP) sprModel.sp = ports[l].value;
		end
	endtask

	task automatic checkValue(input string what, input logic [255:0] got,
			input logic [255:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic stepCycle(input laneOps_pkg::issueBundle_t ops);
		regDefs_pkg::sprVals_t side;
		@(posedge clock);
		side = sprIn;	// What the specials load at this edge
		issue <= ops;
		sprIn <= sideNext;
		hold <= holdNext;
		retire(ex2Exp, side);
		ex2Exp = ex1Exp;
		ex1Exp = readExp;
		readExp = '{a: predictLane(ops.a), b: predictLane(ops.b), c: predictLane(ops.c)};
		@(negedge clock);
		checkValue("wbLanes", wbLanes, ex2Exp);
		checkValue("sprOut", sprOut, sprModel);
	endtask

	// Leaves the result of ops on wbLanes
	task automatic runOp(input laneOps_pkg::issueBundle_t ops);
		stepCycle(ops);
		stepCycle(idleOps());
		stepCycle(idleOps());
	endtask

	task automatic waitForResult(input regDefs_pkg::regId_t id, output int cycles);
		cycles = 0;
		while (wbLanes.a.id != id && cycles < 8) begin
			stepCycle(idleOps());
			cycles++;
		end
		if (wbLanes.a.id != id) begin
			timeoutCount++;
			$display("Timeout: no lane A result for register %0d after %0d cycles", id, cycles);
		end
	endtask

	task automatic resetState();
		checkValue("wbLanes after reset", wbLanes, {idleWrite, idleWrite, idleWrite});
		checkValue("sprOut after reset", sprOut, 256'h0);
	endtask

	task automatic moveAndAlu();
		regDefs_pkg::imm_t immA;
		regDefs_pkg::imm_t immB;
		immA = randImm() | 33'h1_0000_0000;	// Negative
		immB = randImm() & 33'h0_ffff_ffff;
		runOp('{a: movImm(6'd1, immA), b: movImm(6'd2, immB), c: movImm(6'd3, randImm())});
		checkValue("r1 load", wbLanes.a.value, {31'h7fff_ffff, immA});
		checkValue("r2 load", wbLanes.b.value, {31'h0, immB});
		stepCycle(idleOps());
		runOp('{a: aluLane(laneOps_pkg::ALU_ADD, 6'd1, 6'd2, 6'd4),
			b: aluLane(laneOps_pkg::ALU_SUB, 6'd1, 6'd3, 6'd5),
			c: aluLane(laneOps_pkg::ALU_AND, 6'd2, 6'd3, 6'd6)});
		runOp('{a: aluLane(laneOps_pkg::ALU_OR, 6'd1, 6'd3, 6'd7),
			b: aluLane(laneOps_pkg::ALU_XOR, 6'd2, 6'd3, 6'd8),
			c: aluLane(laneOps_pkg::ALU_SHL, 6'd1, 6'd3, 6'd9)});
	endtask

	task automatic forwarding();
		regDefs_pkg::imm_t immA;
		immA = randImm();
		// r10 written by lanes A and C together
		stepCycle('{a: movImm(6'd10, immA), b: aluLane(laneOps_pkg::ALU_ADD, 6'd1, 6'd2, 6'd11),
			c: movImm(6'd10, randImm())});
		stepCycle('{a: aluLane(laneOps_pkg::ALU_MOV, 6'd10, `GR_ZZR, 6'd12),
			b: aluLane(laneOps_pkg::ALU_ADD, 6'd11, 6'd10, 6'd13), c: nopLane()});
		stepCycle('{a: nopLane(), b: aluLane(laneOps_pkg::ALU_MOV, 6'd10, `GR_ZZR, 6'd14),
			c: aluLane(laneOps_pkg::ALU_SUB, 6'd12, 6'd11, 6'd15)});
		stepCycle(idleOps());
		checkValue("r12 from EX1 lane A", wbLanes.a.value, signExt(immA));
		stepCycle(idleOps());
		checkValue("r14 from EX2 lane A", wbLanes.b.value, signExt(immA));
		stepCycle(idleOps());
	endtask

	task automatic writeConflict();
		regDefs_pkg::imm_t immC;
		immC = randImm();
		stepCycle('{a: movImm(6'd20, randImm()), b: movImm(6'd20, randImm()),
			c: movImm(6'd20, immC)});
		stepCycle(idleOps());
		stepCycle(idleOps());
		runOp('{a: aluLane(laneOps_pkg::ALU_MOV, 6'd20, `GR_ZZR, 6'd21),
			b: nopLane(), c: nopLane()});
		checkValue("r20 after three writes", wbLanes.a.value, signExt(immC));
	endtask

	task automatic specialsAndControl();
		regDefs_pkg::imm_t spImm;
		regDefs_pkg::regVal_t dlrSide;
		runOp('{a: aluLane(laneOps_pkg::ALU_MOV, `GR_PC, `GR_ZZR, 6'd22),
			b: aluLane(laneOps_pkg::ALU_MOV, `GR_GBR, `GR_ZZR, 6'd23),
			c: aluLane(laneOps_pkg::ALU_MOV, `GR_LR, `GR_ZZR, 6'd24)});
		checkValue("PC read", wbLanes.a.value, {32'h0, ctrlRegs.pc});
		checkValue("GBR read", wbLanes.b.value, {32'h0, ctrlRegs.gbr});
		checkValue("LR read", wbLanes.c.value, {32'h0, ctrlRegs.lr});
		runOp('{a: aluLane(laneOps_pkg::ALU_MOV, `GR_ZZR, `GR_ZZR, 6'd25),
			b: nopLane(), c: nopLane()});
		checkValue("ZZR read", wbLanes.a.value, 64'h0);
		spImm = randImm();
		runOp('{a: nopLane(), b: movImm(`GR_SP, spImm), c: nopLane()});
		stepCycle(idleOps());	// SP loads here
		checkValue("SP after lane B write", sprOut.sp, signExt(spImm));
		dlrSide = {$urandom, $urandom};
		sideNext.dlr = dlrSide;
		stepCycle(idleOps());
		stepCycle(idleOps());
		checkValue("DLR follows sprIn", sprOut.dlr, dlrSide);
	endtask

	task automatic holdFreeze();
		regDefs_pkg::wbBundle_t frozenWb;
		regDefs_pkg::sprVals_t frozenSpr;
		int cycles;
		stepCycle('{a: movImm(6'd26, randImm()), b: nopLane(), c: nopLane()});
		stepCycle('{a: aluLane(laneOps_pkg::ALU_ADD, 6'd1, 6'd2, 6'd27),
			b: nopLane(), c: nopLane()});
		holdNext = 1'b1;
		stepCycle(idleOps());
		frozenWb = wbLanes;
		frozenSpr = sprOut;
		for (int i = 0; i < 5; i++) begin
			@(posedge clock);
			issue <= '{a: movImm(6'd29, randImm()), b: movImm(`GR_SP, randImm()),
				c: movImm(6'd29, randImm())};	// Must be ignored
			sprIn <= ~sideNext;
			@(negedge clock);
			checkValue("wbLanes under hold", wbLanes, frozenWb);
			checkValue("sprOut under hold", sprOut, frozenSpr);
		end
		@(posedge clock);
		issue <= idleOps();
		sprIn <= sideNext;
		hold <= 1'b0;
		holdNext = 1'b0;
		@(negedge clock);
		checkValue("wbLanes at release", wbLanes, frozenWb);
		waitForResult(6'd27, cycles);
		checkValue("cycles from release to r27", cycles, 1);
		checkValue("r27 value", wbLanes.a.value, modelRegs[1] + modelRegs[2]);
	endtask

	initial begin
		void'($urandom(32'h810f63c8));
		errorCount = 0;
		checkCount = 0;
		timeoutCount = 0;
		rstN = 1'b0;
		hold = 1'b0;
		holdNext = 1'b0;
		// Busy inputs during reset, so only the reset can leave the outputs idle
		issue = '{a: movImm(6'd30, randImm()), b: movImm(`GR_SP, randImm()),
			c: movImm(6'd31, randImm())};
		sprIn = '1;
		sideNext = '0;
		ctrlRegs = '{pc: $urandom, gbr: $urandom | 32'h8000_0000, lr: $urandom};
		readExp = '{a: idleWrite, b: idleWrite, c: idleWrite};
		ex1Exp = readExp;
		ex2Exp = readExp;
		sprModel = '0;
		for (int i = 0; i < 4; i++)
			@(posedge clock);
		rstN <= 1'b1;
		issue <= idleOps();
		sprIn <= '0;
		@(negedge clock);
		resetState();
		moveAndAlu();
		forwarding();
		writeConflict();
		specialsAndControl();
		holdFreeze();
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+.
regDefs_pkg.sv
laneOps_pkg.sv
sprReg.sv
gprFile.sv
pipeStage.sv
laneAlu.sv
execCore.sv
execCore_tb.sv

//--- gprFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file, 6 read and 3 write ports
// Per-lane banks with last-writer masks
// Special id decode and EX1/EX2 forwarding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "execCore_params.svh"

module gprFile (
	input  logic                      clock,
	input  logic                      rstN,
	input  logic                      hold,
	input  laneOps_pkg::issueBundle_t issue,
	input  regDefs_pkg::ctrlRegs_t    ctrlRegs,
	input  regDefs_pkg::sprVals_t     sprIn,
	input  regDefs_pkg::wbBundle_t    fwdEx1,
	input  regDefs_pkg::wbBundle_t    wbEx2,
	output laneOps_pkg::ex1Bundle_t   operands,
	output regDefs_pkg::sprVals_t     sprOut
);

	localparam int gprIdxW = `REG_ID_W - 1;
	localparam int gprCount = 2 ** gprIdxW;

	regDefs_pkg::regVal_t bank [3][gprCount];	// One bank per writing lane
	logic [gprCount-1:0] selB;	// Lane B wrote last
	logic [gprCount-1:0] selC;	// Lane C wrote last

	regDefs_pkg::writePort_t wrPorts [3];
	regDefs_pkg::writePort_t fwdPorts [6];	// Highest forward priority first
	laneOps_pkg::laneIssue_t lanes [3];
	regDefs_pkg::regId_t srcId [6];
	regDefs_pkg::regVal_t srcVal [6];

	sprReg #(.sprId(`GR_DLR)) dlrReg (
		.clock(clock), .rstN(rstN), .hold(hold),
		.wb(wbEx2), .sideIn(sprIn.dlr), .value(sprOut.dlr)
	);

	sprReg #(.sprId(`GR_DHR)) dhrReg (
		.clock(clock), .rstN(rstN), .hold(hold),
		.wb(wbEx2), .sideIn(sprIn.dhr), .value(sprOut.dhr)
	);

	sprReg #(.sprId(`GR_SP)) spReg (
		.clock(clock), .rstN(rstN), .hold(hold),
		.wb(wbEx2), .sideIn(sprIn.sp), .value(sprOut.sp)
	);

	// Stored value of one source, before forwarding
	function automatic regDefs_pkg::regVal_t readSource(input regDefs_pkg::regId_t id,
			input regDefs_pkg::imm_t imm);
		logic [gprIdxW-1:0] idx;
		idx = id[gprIdxW-1:0];
		if (!id[`REG_ID_W-1]) begin
			if (selC[idx])
				return bank[2][idx];
			else if (selB[idx])
				return bank[1][idx];
			return bank[0][idx];
		end
		case (id)
			`GR_DLR: return sprOut.dlr;
			`GR_DHR: return sprOut.dhr;
			`GR_SP:  return sprOut.sp;
			`GR_PC:  return {{(`XLEN-`CTRL_W){1'b0}}, ctrlRegs.pc};
			`GR_GBR: return {{(`XLEN-`CTRL_W){1'b0}}, ctrlRegs.gbr};
			`GR_LR:  return {{(`XLEN-`CTRL_W){1'b0}}, ctrlRegs.lr};
			`GR_IMM: return {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
			default: return '0;	// ZZR and unassigned ids
		endcase
	endfunction

	always_comb begin
		lanes[0] = issue.a;
		lanes[1] = issue.b;
		lanes[2] = issue.c;
		wrPorts[0] = wbEx2.a;
		wrPorts[1] = wbEx2.b;
		wrPorts[2] = wbEx2.c;
		fwdPorts[0] = fwdEx1.a;
		fwdPorts[1] = fwdEx1.b;
		fwdPorts[2] = fwdEx1.c;
		fwdPorts[3] = wbEx2.a;
		fwdPorts[4] = wbEx2.b;
		fwdPorts[5] = wbEx2.c;
		for (int l = 0; l < 3; l++) begin
			srcId[2*l] = lanes[l].rs;
			srcId[2*l+1] = lanes[l].rt;
		end
	end

	// Walk forward sources from lowest priority up so the best match lands last
	always_comb begin
		for (int p = 0; p < 6; p++) begin
			srcVal[p] = readSource(srcId[p], lanes[p/2].imm);
			if (srcId[p] != `GR_IMM && srcId[p] != `GR_ZZR) begin
				for (int f = 5; f >= 0; f--) begin
					if (fwdPorts[f].id == srcId[p])
						srcVal[p] = fwdPorts[f].value;
				end
			end
		end
	end

	assign operands.a = '{op: issue.a.op, aVal: srcVal[0], bVal: srcVal[1], rn: issue.a.rn};
	assign operands.b = '{op: issue.b.op, aVal: srcVal[2], bVal: srcVal[3], rn: issue.b.rn};
	assign operands.c = '{op: issue.c.op, aVal: srcVal[4], bVal: srcVal[5], rn: issue.c.rn};

	always_ff @(posedge clock) begin
		if (!hold) begin
			for (int l = 0; l < 3; l++) begin
				if (!wrPorts[l].id[`REG_ID_W-1])
					bank[l][wrPorts[l].id[gprIdxW-1:0]] <= wrPorts[l].value;
			end
		end
	end

	// Later lanes overwrite the mask, so C beats B beats A
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			selB <= '0;
			selC <= '0;
		end else if (!hold) begin
			for (int l = 0; l < 3; l++) begin
				if (!wrPorts[l].id[`REG_ID_W-1]) begin
					selB[wrPorts[l].id[gprIdxW-1:0]] <= (l == 1);
					selC[wrPorts[l].id[gprIdxW-1:0]] <= (l == 2);
				end
			end
		end
	end

endmodule

//--- laneAlu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three-lane ALU
// EX1 operands in, writeback ports out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "execCore_params.svh"

module laneAlu (
	input  laneOps_pkg::ex1Bundle_t operands,
	output regDefs_pkg::wbBundle_t  results
);

	localparam int shiftW = $clog2(`XLEN);

	function automatic regDefs_pkg::writePort_t execLane(
			input laneOps_pkg::laneOperands_t opnd);
		regDefs_pkg::writePort_t res;
		res.id = opnd.rn;	// Destination rides along
		case (opnd.op)
			laneOps_pkg::ALU_MOV: res.value = opnd.aVal;
			laneOps_pkg::ALU_ADD: res.value = opnd.aVal + opnd.bVal;
			laneOps_pkg::ALU_SUB: res.value = opnd.aVal - opnd.bVal;
			laneOps_pkg::ALU_AND: res.value = opnd.aVal & opnd.bVal;
			laneOps_pkg::ALU_OR:  res.value = opnd.aVal | opnd.bVal;
			laneOps_pkg::ALU_XOR: res.value = opnd.aVal ^ opnd.bVal;
			laneOps_pkg::ALU_SHL: res.value = opnd.aVal << opnd.bVal[shiftW-1:0];
			default:              res.value = '0;	// Spare opcode
		endcase
		return res;
	endfunction

	assign results.a = execLane(operands.a);
	assign results.b = execLane(operands.b);
	assign results.c = execLane(operands.c);

endmodule

//--- laneOps_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane operation types
// ALU opcodes, issue bundle, EX1 operand bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package laneOps_pkg;

	typedef enum logic [2:0] {
		ALU_MOV = 3'd0,	// Pass a through
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd3,
		ALU_OR  = 3'd4,
		ALU_XOR = 3'd5,
		ALU_SHL = 3'd6	// Shift by low bits of b
	} aluOp_t;

	// One lane as presented by issue
	typedef struct packed {
		aluOp_t op;
		regDefs_pkg::regId_t rs;
		regDefs_pkg::regId_t rt;
		regDefs_pkg::regId_t rn;
		regDefs_pkg::imm_t imm;
	} laneIssue_t;

	typedef struct packed {
		laneIssue_t a;
		laneIssue_t b;
		laneIssue_t c;
	} issueBundle_t;

	// Resolved operands for one lane in EX1
	typedef struct packed {
		aluOp_t op;
		regDefs_pkg::regVal_t aVal;
		regDefs_pkg::regVal_t bVal;
		regDefs_pkg::regId_t rn;
	} laneOperands_t;

	typedef struct packed {
		laneOperands_t a;
		laneOperands_t b;
		laneOperands_t c;
	} ex1Bundle_t;

endpackage

//--- pipeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Holdable pipeline register
// Payload type and reset value set per instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module pipeStage #(
	parameter type payload_t = logic,
	parameter payload_t resetValue = '0
) (
	input  logic     clock,
	input  logic     rstN,
	input  logic     hold,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			q <= resetValue;
		else if (!hold)	// Stall keeps current contents
			q <= d;
	end

endmodule

//--- regDefs_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file types
// Ids, values, immediates, control and special register sets, write ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "execCore_params.svh"

package regDefs_pkg;

	typedef logic [`REG_ID_W-1:0] regId_t;
	typedef logic [`XLEN-1:0] regVal_t;
	typedef logic [`IMM_W-1:0] imm_t;

	// Control values, zero extended on read
	typedef struct packed {
		logic [`CTRL_W-1:0] pc;
		logic [`CTRL_W-1:0] gbr;
		logic [`CTRL_W-1:0] lr;
	} ctrlRegs_t;

	typedef struct packed {
		regVal_t dlr;
		regVal_t dhr;
		regVal_t sp;
	} sprVals_t;

	typedef struct packed {
		regId_t id;	// ZZR when lane does not write
		regVal_t value;
	} writePort_t;

	// Shared by EX1 forwarding and EX2 writeback
	typedef struct packed {
		writePort_t a;
		writePort_t b;
		writePort_t c;
	} wbBundle_t;

endpackage

//--- sprReg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Special register with three lane write ports
// Follows a side input when no lane writes it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "execCore_params.svh"

module sprReg #(
	parameter regDefs_pkg::regId_t sprId = `GR_DLR
) (
	input  logic                   clock,
	input  logic                   rstN,
	input  logic                   hold,
	input  regDefs_pkg::wbBundle_t wb,
	input  regDefs_pkg::regVal_t   sideIn,
	output regDefs_pkg::regVal_t   value
);

	regDefs_pkg::regVal_t nextValue;

	// Lane A has first claim here
	always_comb begin
		if (wb.a.id == sprId)
			nextValue = wb.a.value;
		else if (wb.b.id == sprId)
			nextValue = wb.b.value;
		else if (wb.c.id == sprId)
			nextValue = wb.c.value;
		else
			nextValue = sideIn;
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			value <= '0;
		else if (!hold)
			value <= nextValue;
	end

endmodule
